//--- rv_defines.svh
// Width macros for the RV32I pipeline
// Values fixed by the RV32I ISA and shared by every RTL file and the testbench
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data word width
`define RV_XLEN 32

// Register address width
`define RV_RADDR_W 5

// Register count, x0 included
`define RV_NREGS 32

`endif

//--- rv_pkg.sv
// Shared encodings and pipeline records for the three-stage RV32I core
// Only OP, OP-IMM and LUI are decoded; every other major opcode is illegal
`default_nettype none
`include "rv_defines.svh"

package rv_pkg;

  // ========================================
  // Encodings
  // ========================================

  // Supported major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    XOR    = 3'd4,
    SLT    = 3'd5,
    PASS_B = 3'd6
  } alu_op_e;

  // Execute operand source
  // FWD_NONE takes the value read in decode, FWD_WB the retiring result
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01
  } fwd_sel_e;

  // ========================================
  // Pipeline records
  // ========================================

  // Decoded control
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;   // Operand B from the immediate
    logic    rf_we;     // Writes rd
    logic    illegal;   // Unsupported encoding
  } ctrl_t;

  // Decode to execute register
  typedef struct packed {
    logic                   valid;
    ctrl_t                  ctrl;
    logic [`RV_RADDR_W-1:0] rs1;
    logic [`RV_RADDR_W-1:0] rs2;
    logic [`RV_RADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]    rs1_val;
    logic [`RV_XLEN-1:0]    rs2_val;
    logic [`RV_XLEN-1:0]    imm;
  } id_ex_t;

  // Execute to writeback register, also the core output
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic                   rf_we;
    logic [`RV_RADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]    data;   // Zero for an illegal instruction
  } retire_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
// 32-entry register file, two combinational read ports, one write port
// x0 reads zero; a same-cycle write is bypassed to the read ports
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`RV_RADDR_W-1:0] raddr_a_i,
  input  logic [`RV_RADDR_W-1:0] raddr_b_i,
  input  logic                   we_i,
  input  logic [`RV_RADDR_W-1:0] waddr_i,
  input  logic [`RV_XLEN-1:0]    wdata_i,
  output logic [`RV_XLEN-1:0]    rdata_a_o,
  output logic [`RV_XLEN-1:0]    rdata_b_o
);

  // x1 to x31 only, x0 has no storage
  logic [`RV_XLEN-1:0] regs_q [1:`RV_NREGS-1];

  // Zero on reset, writes to x0 dropped
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // One read port, with write-through for a distance-2 dependency
  function automatic logic [`RV_XLEN-1:0] read_port(
    input logic [`RV_RADDR_W-1:0] addr
  );
    logic [`RV_XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (we_i && (addr == waddr_i)) begin
      val = wdata_i;
    end else begin
      val = regs_q[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  // x0 reads zero even while the pipeline tries to write it
  x0_reads_zero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((raddr_a_i != '0) || (rdata_a_o == '0)) && ((raddr_b_i != '0) || (rdata_b_o == '0)))
    else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

//--- rv_decode.sv
// Decoder for ADD SUB AND OR XOR SLT ADDI ANDI ORI XORI LUI
// Anything else is flagged illegal and never writes a register
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_decode (
  input  logic [31:0]         instr_i,
  output rv_pkg::ctrl_t       ctrl_o,
  output logic [`RV_XLEN-1:0] imm_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i_type;
  logic [`RV_XLEN-1:0] imm_u_type;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // I-type sign extended, U-type upper 20 bits
  assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    // Defaults give a harmless ADD with no write
    ctrl_o.alu_op  = rv_pkg::ADD;
    ctrl_o.use_imm = 1'b0;
    ctrl_o.rf_we   = 1'b0;
    ctrl_o.illegal = 1'b0;
    imm_o          = imm_i_type;

    case (opcode)
      // Register-register
      rv_pkg::OP: begin
        ctrl_o.rf_we = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  ctrl_o.alu_op = rv_pkg::ADD;
            3'b010:  ctrl_o.alu_op = rv_pkg::SLT;
            3'b100:  ctrl_o.alu_op = rv_pkg::XOR;
            3'b110:  ctrl_o.alu_op = rv_pkg::OR;
            3'b111:  ctrl_o.alu_op = rv_pkg::AND;
            default: ctrl_o.illegal = 1'b1;
          endcase
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
          ctrl_o.alu_op = rv_pkg::SUB;
        end else begin
          ctrl_o.illegal = 1'b1;
        end
      end
      // Register-immediate, SLTI and shifts not supported
      rv_pkg::OP_IMM: begin
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.use_imm = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = rv_pkg::ADD;
          3'b100:  ctrl_o.alu_op = rv_pkg::XOR;
          3'b110:  ctrl_o.alu_op = rv_pkg::OR;
          3'b111:  ctrl_o.alu_op = rv_pkg::AND;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      // LUI passes the U immediate straight through
      rv_pkg::LUI: begin
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.alu_op  = rv_pkg::PASS_B;
        imm_o          = imm_u_type;
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words retire without a write
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we  = 1'b0;
      ctrl_o.alu_op = rv_pkg::ADD;
    end
  end

endmodule

`default_nettype wire

//--- rv_forward_unit.sv
// Operand forwarding for the execute stage
// Only distance 1 needs it; the regfile write-through covers distance 2
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_forward_unit (
  input  logic [`RV_RADDR_W-1:0] rs1_i,
  input  logic [`RV_RADDR_W-1:0] rs2_i,
  input  rv_pkg::retire_t        retire_i,
  output rv_pkg::fwd_sel_e       fwd_a_o,
  output rv_pkg::fwd_sel_e       fwd_b_o
);

  // Retire record that really updates a register
  logic wb_writes;

  // x0 never forwards, it must keep reading zero
  assign wb_writes = retire_i.valid && !retire_i.illegal && retire_i.rf_we &&
                     (retire_i.rd != '0);

  // ========================================
  // Address match per operand
  // ========================================

  assign fwd_a_o = (wb_writes && (rs1_i == retire_i.rd)) ? rv_pkg::FWD_WB
                                                         : rv_pkg::FWD_NONE;

  // Operand B forwards even for immediates; the execute mux ignores it then
  assign fwd_b_o = (wb_writes && (rs2_i == retire_i.rd)) ? rv_pkg::FWD_WB
                                                         : rv_pkg::FWD_NONE;

endmodule

`default_nettype wire

//--- rv_execute.sv
// Execute stage, operand muxes and single-cycle ALU
// SLT compares signed; PASS_B carries the LUI immediate
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_execute (
  input  rv_pkg::id_ex_t      id_ex_i,
  input  rv_pkg::fwd_sel_e    fwd_a_i,
  input  rv_pkg::fwd_sel_e    fwd_b_i,
  input  logic [`RV_XLEN-1:0] wb_data_i,
  output logic [`RV_XLEN-1:0] result_o
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op_b;
  logic                lt_signed;

  // ========================================
  // Operand selection
  // ========================================

  // rs1 value latched in decode, or the result retiring now
  assign op_a = (fwd_a_i == rv_pkg::FWD_WB) ? wb_data_i : id_ex_i.rs1_val;

  assign rs2_fwd = (fwd_b_i == rv_pkg::FWD_WB) ? wb_data_i : id_ex_i.rs2_val;

  // Immediate wins for OP-IMM and LUI
  assign op_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;

  assign lt_signed = $signed(op_a) < $signed(op_b);

  // ========================================
  // ALU
  // ========================================

  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      rv_pkg::ADD:    result_o = op_a + op_b;
      rv_pkg::SUB:    result_o = op_a - op_b;
      rv_pkg::AND:    result_o = op_a & op_b;
      rv_pkg::OR:     result_o = op_a | op_b;
      rv_pkg::XOR:    result_o = op_a ^ op_b;
      rv_pkg::SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      rv_pkg::PASS_B: result_o = op_b;
      default:        result_o = '0;
    endcase
  end

  // Decode always picks an operation, so a valid stage never sees X here
  always_comb begin
    if (id_ex_i.valid) begin
      assert (!$isunknown(id_ex_i.ctrl.alu_op))
        else $error("ALU operation unknown for a valid instruction");
    end
  end

endmodule

`default_nettype wire

//--- rv_core.sv
// Three-stage RV32I pipeline of instruction register, decode/execute and retire
// Fixed 3-cycle latency, no back-pressure, no stalls; forwarding covers all hazards
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  logic [31:0]     instr_i,
  output rv_pkg::retire_t retire_o
);

  // ========================================
  // Stage 1 instruction register
  // ========================================

  logic                ir_valid_q;
  logic [31:0]         ir_q;
  rv_pkg::ctrl_t       de_ctrl;
  logic [`RV_XLEN-1:0] de_imm;
  logic [`RV_XLEN-1:0] rf_rdata_a;
  logic [`RV_XLEN-1:0] rf_rdata_b;

  // ========================================
  // Stage 2 decode to execute
  // ========================================

  rv_pkg::id_ex_t      id_ex_q;
  rv_pkg::fwd_sel_e    ex_fwd_a;
  rv_pkg::fwd_sel_e    ex_fwd_b;
  logic [`RV_XLEN-1:0] ex_result;

  // ========================================
  // Stage 3 retire
  // ========================================

  rv_pkg::retire_t     retire_q;
  logic                rf_we;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ir_valid_q <= 1'b0;
    end else begin
      ir_valid_q <= instr_valid_i;
    end
  end

  // Instruction word only loads on a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      ir_q <= instr_i;
    end
  end

  rv_decode u_decode (
    .instr_i (ir_q),
    .ctrl_o  (de_ctrl),
    .imm_o   (de_imm)
  );

  // Write-through covers a distance-2 dependency in the same cycle
  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ir_q[19:15]),
    .raddr_b_i (ir_q[24:20]),
    .we_i      (rf_we),
    .waddr_i   (retire_q.rd),
    .wdata_i   (retire_q.data),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  // Loads every cycle since nothing ever holds the pipe
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q.valid   <= ir_valid_q;
      id_ex_q.ctrl    <= de_ctrl;
      id_ex_q.rs1     <= ir_q[19:15];
      id_ex_q.rs2     <= ir_q[24:20];
      id_ex_q.rd      <= ir_q[11:7];
      id_ex_q.rs1_val <= rf_rdata_a;
      id_ex_q.rs2_val <= rf_rdata_b;
      id_ex_q.imm     <= de_imm;
    end
  end

  rv_forward_unit u_forward_unit (
    .rs1_i    (id_ex_q.rs1),
    .rs2_i    (id_ex_q.rs2),
    .retire_i (retire_q),
    .fwd_a_o  (ex_fwd_a),
    .fwd_b_o  (ex_fwd_b)
  );

  rv_execute u_execute (
    .id_ex_i   (id_ex_q),
    .fwd_a_i   (ex_fwd_a),
    .fwd_b_i   (ex_fwd_b),
    .wb_data_i (retire_q.data),
    .result_o  (ex_result)
  );

  // Retire record with zero data for illegal instructions
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      retire_q <= '0;
    end else begin
      retire_q.valid   <= id_ex_q.valid;
      retire_q.illegal <= id_ex_q.ctrl.illegal;
      retire_q.rf_we   <= id_ex_q.ctrl.rf_we;
      retire_q.rd      <= id_ex_q.rd;
      retire_q.data    <= id_ex_q.ctrl.illegal ? '0 : ex_result;
    end
  end

  // Register write from the retire stage
  assign rf_we = retire_q.valid && !retire_q.illegal && retire_q.rf_we;

  assign retire_o = retire_q;

  // Nothing retires in the first cycle after reset release
  no_retire_after_reset_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |=> !retire_o.valid)
    else $error("retire_o.valid set in the first cycle after reset");

endmodule

`default_nettype wire

//--- tb_rv_core.sv
// Testbench for rv_core with a sequential reference model and an in-order retire queue
// Latency is measured in falling edges from the drive edge to the edge that sees retire_o
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module tb_rv_core;

  localparam int CLK_PERIOD     = 100;
  localparam int LATENCY        = 3;
  localparam int RANDOM_N       = 200;
  localparam int MAX_GAP        = 3;
  localparam int DIRECTED_SLOTS = 64;
  // Issue slots of all tests, drains and reset, plus 20 cycles of margin
  localparam int WATCHDOG_CYCLES = 3 + DIRECTED_SLOTS + RANDOM_N * (MAX_GAP + 1) + 6 * 6 + 20;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  logic [31:0]     instr_i;
  rv_pkg::retire_t retire_o;

  // Reference register state with x0 left at zero
  logic [`RV_XLEN-1:0] model_regs [0:`RV_NREGS-1];
  rv_pkg::retire_t     exp_q [$];
  int                  issue_q [$];
  int                  cycle_cnt = 0;
  int                  issue_cnt = 0;
  int                  check_cnt = 0;
  int                  err_cnt = 0;
  int                  chk_mark = 0;
  int                  err_mark = 0;
  integer              seed;
  rv_pkg::retire_t     popped;
  int                  popped_cycle;

  rv_core u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .retire_o      (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ========================================
  // Encoders and reference model
  // ========================================

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, rv_pkg::LUI};
  endfunction

  // Runs one instruction on model_regs and returns the record it must retire
  function automatic rv_pkg::retire_t ref_exec(input logic [31:0] w);
    rv_pkg::retire_t     r;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] res;
    logic                ok;
    a   = model_regs[w[19:15]];
    b   = model_regs[w[24:20]];
    imm = {{20{w[31]}}, w[31:20]};
    res = '0;
    ok  = 1'b1;
    if (w[6:0] == rv_pkg::OP && w[31:25] == 7'b0000000) begin
      case (w[14:12])
        3'b000:  res = a + b;
        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: ok = 1'b0;
      endcase
    end else if (w[6:0] == rv_pkg::OP && w[31:25] == F7_SUB && w[14:12] == 3'b000) begin
      res = a - b;
    end else if (w[6:0] == rv_pkg::OP_IMM) begin
      case (w[14:12])
        3'b000:  res = a + imm;
        3'b100:  res = a ^ imm;
        3'b110:  res = a | imm;
        3'b111:  res = a & imm;
        default: ok = 1'b0;
      endcase
    end else if (w[6:0] == rv_pkg::LUI) begin
      res = {w[31:12], 12'b0};
    end else begin
      ok = 1'b0;
    end
    r.valid   = 1'b1;
    r.illegal = !ok;
    r.rf_we   = ok;
    r.rd      = w[11:7];
    r.data    = ok ? res : '0;
    if (ok && w[11:7] != 5'd0) begin
      model_regs[w[11:7]] = res;
    end
    return r;
  endfunction

  // ========================================
  // Stimulus and checks
  // ========================================

  task automatic issue(input logic [31:0] w);
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i       = w;
    exp_q.push_back(ref_exec(w));
    issue_q.push_back(cycle_cnt);
    issue_cnt++;
  endtask

  // Idle slots carry a junk word that must be ignored
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      instr_i       = $random(seed);
    end
  endtask

  function automatic string format_retire(input rv_pkg::retire_t r);
    return $sformatf("v=%b ill=%b we=%b rd=%0d data=%h", r.valid, r.illegal, r.rf_we,
                     r.rd, r.data);
  endfunction

  task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] time %0t retire_o: expected %s, got %s", $time,
               format_retire(exp), format_retire(act));
    end
  endtask

  // Waits for every instruction in flight and then reports the test
  task automatic finish_test(input string name);
    idle(1);
    while (exp_q.size() != 0) @(posedge clk_i);
    $display("test %0s done: %0d retires checked, %0d errors", name,
             check_cnt - chk_mark, err_cnt - err_mark);
    chk_mark = check_cnt;
    err_mark = err_cnt;
  endtask

  task automatic random_instr(output logic [31:0] w);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r   = $random(seed);
    rd  = {2'b00, r[5:3]};
    rs1 = {2'b00, r[8:6]};
    rs2 = {2'b00, r[11:9]};
    case (r[2:0])
      // Funct combinations outside the subset come out illegal
      3'd0, 3'd1: w = r_type(r[15] ? F7_SUB : 7'b0000000, rs2, rs1, r[14:12], rd);
      3'd2, 3'd3: w = i_type(r[31:20], rs1, r[14:12], rd);
      3'd4:       w = u_type(r[31:12], rd);
      3'd5:       w = r_type(7'b0000001, rs2, rs1, r[14:12], rd);
      3'd6:       w = {r[31:12], rd, 7'b0000011};
      default:    w = $random(seed);
    endcase
  endtask

  // Pops one expected record per retire, in order, at a stable sample point
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (retire_o.valid) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("At time %0t retire_o.valid is set with no instruction in flight", $time);
        end else begin
          popped       = exp_q.pop_front();
          popped_cycle = issue_q.pop_front();
          if (cycle_cnt - popped_cycle != LATENCY) begin
            err_cnt++;
            $display("At time %0t a retire came %0d cycles after issue instead of %0d",
                     $time, cycle_cnt - popped_cycle, LATENCY);
          end
          check_retire(popped, retire_o);
        end
      end else if (exp_q.size() != 0 && cycle_cnt - issue_q[0] > LATENCY) begin
        err_cnt++;
        $display("At time %0t the instruction issued at cycle %0d never retired",
                 $time, issue_q[0]);
        popped       = exp_q.pop_front();
        popped_cycle = issue_q.pop_front();
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    seed          = 32'h3abf9eb7;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < `RV_NREGS; i++) model_regs[i] = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Quiet pipeline after reset and then one instruction for the latency
    idle(5);
    issue(i_type(12'd5, 5'd0, F3_ADD, 5'd1));
    finish_test("reset_latency");

    // Independent writes read back through ADD with x0
    issue(i_type(12'h123, 5'd0, F3_ADD, 5'd1));
    issue(i_type(12'hff9, 5'd0, F3_ADD, 5'd2));
    issue(u_type(20'habcde, 5'd3));
    issue(i_type(12'h7f0, 5'd0, F3_OR, 5'd4));
    idle(3);
    issue(r_type(7'd0, 5'd0, 5'd1, F3_ADD, 5'd5));
    issue(r_type(7'd0, 5'd0, 5'd2, F3_ADD, 5'd6));
    issue(r_type(7'd0, 5'd0, 5'd3, F3_ADD, 5'd7));
    issue(r_type(7'd0, 5'd4, 5'd0, F3_ADD, 5'd8));
    finish_test("independent");

    // Distance 1 on both operands, then distance 2, then distance 3
    issue(i_type(12'd10, 5'd0, F3_ADD, 5'd1));
    issue(i_type(12'd1, 5'd1, F3_ADD, 5'd1));
    issue(r_type(7'd0, 5'd1, 5'd1, F3_ADD, 5'd2));
    issue(r_type(F7_SUB, 5'd1, 5'd2, F3_ADD, 5'd3));
    issue(i_type(12'h0f0, 5'd3, F3_XOR, 5'd4));
    issue(i_type(12'd3, 5'd0, F3_ADD, 5'd5));
    issue(i_type(12'hffc, 5'd0, F3_ADD, 5'd6));
    issue(r_type(7'd0, 5'd6, 5'd5, F3_ADD, 5'd7));
    issue(i_type(12'd9, 5'd0, F3_ADD, 5'd8));
    issue(i_type(12'd1, 5'd0, F3_ADD, 5'd9));
    issue(i_type(12'd2, 5'd0, F3_ADD, 5'd10));
    issue(r_type(7'd0, 5'd8, 5'd8, F3_OR, 5'd11));
    issue(r_type(7'd0, 5'd11, 5'd6, F3_SLT, 5'd12));
    issue(r_type(7'd0, 5'd12, 5'd7, F3_XOR, 5'd13));
    finish_test("forwarding");

    // Writes to x0 retire but must never be seen
    issue(i_type(12'd55, 5'd0, F3_ADD, 5'd0));
    issue(r_type(7'd0, 5'd0, 5'd0, F3_ADD, 5'd1));
    issue(u_type(20'h12345, 5'd0));
    issue(i_type(12'd0, 5'd0, F3_OR, 5'd2));
    idle(2);
    issue(r_type(7'd0, 5'd0, 5'd0, F3_ADD, 5'd3));
    finish_test("x0_writes");

    // Illegal opcode and funct codes leave x1 untouched
    issue(i_type(12'd77, 5'd0, F3_ADD, 5'd1));
    issue(32'h00a00083);
    issue(r_type(7'd0, 5'd1, 5'd0, F3_ADD, 5'd2));
    issue(r_type(7'b0000001, 5'd1, 5'd1, F3_ADD, 5'd1));
    issue(i_type(12'd4, 5'd1, F3_SLT, 5'd1));
    issue(r_type(7'd0, 5'd0, 5'd1, F3_ADD, 5'd3));
    finish_test("illegal");

    // Random mix with random gaps
    for (int i = 0; i < RANDOM_N; i++) begin
      logic [31:0] w;
      logic [31:0] g;
      random_instr(w);
      issue(w);
      g = $random(seed);
      idle(int'(g[1:0]));
    end
    finish_test("random");

    if (check_cnt != issue_cnt) begin
      err_cnt++;
      $display("%0d instructions issued but %0d retires checked", issue_cnt, check_cnt);
    end
    $display("%0d instructions, %0d retires checked, %0d errors", issue_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_forward_unit.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_rv_core \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_rv_core > sim.log 2>&1 || echo "simulator returned a nonzero status"
grep -qx "Verification passed" sim.log && echo "run passed" || { cat sim.log; exit 1; }
